// File: build.f
verilog/bpu_pkg.sv
verilog/bpu_update_if.sv
verilog/predictor_table.sv
verilog/branch_predictor.sv
verilog/branch_resolve.sv
verilog/pc_gen.sv
verilog/fetch_top.sv
testbench/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_top

dependencies: {}

sources:
  # Fetch front end RTL, package and interface first.
  - files:
      - verilog/bpu_pkg.sv
      - verilog/bpu_update_if.sv
      - verilog/predictor_table.sv
      - verilog/branch_predictor.sv
      - verilog/branch_resolve.sv
      - verilog/pc_gen.sv
      - verilog/fetch_top.sv
  - target: test
    files:
      - testbench/tb_fetch_top.sv

// File: testbench/fetch_vectors.mem
// Columns: enable was_branch actual_taken actual_target | expected pc predicted_taken mispredicted
// One line per clock cycle, all values hex.
1 0 0 0000 0000 0 0 // Sequential fetch from reset.
1 0 0 0000 0002 0 0
1 0 0 0000 0004 0 0
1 0 0 0000 0006 0 0
1 0 0 0000 0008 0 0 // Branch at 0x08 fetched.
1 1 1 0046 000A 0 1
1 0 0 0000 0046 0 0
1 0 0 0000 0048 0 0 // Loop branch, counter weak not taken.
1 1 1 0046 004A 0 1
1 0 0 0000 0046 0 0
1 0 0 0000 0048 1 0
1 1 1 0046 0046 0 0
1 0 0 0000 0048 1 0
1 1 1 0050 0046 0 1 // Target moved to 0x50.
1 0 0 0000 0050 0 0
1 1 1 0048 0052 0 1
1 0 0 0000 0048 1 0
1 1 1 0050 0050 0 0
0 1 1 0060 0052 0 1 // Stall with a pending report.
0 1 1 0060 0052 0 1
0 0 0 0000 0052 0 0
1 0 0 0000 0052 0 0
1 1 1 0050 0054 0 1
1 0 0 0000 0050 0 0
1 1 1 0048 0052 0 1 // Strong taken stays put.
1 0 0 0000 0048 1 0
1 1 1 0050 0050 1 0
1 1 1 0048 0048 1 0
1 1 0 0000 0050 1 1
1 0 0 0000 004A 0 0

// File: testbench/tb_fetch_top.sv
////////////////////////////////////////////////////////////
// Testbench for the fetch front end.
// Directed vectors from a file, then LCG driven cycles
// checked against a behavioral predictor model.
////////////////////////////////////////////////////////////
module tb_fetch_top import bpu_pkg::*; ();

  localparam int INDEX_BITS  = 3;
  localparam int ENTRIES     = 2 ** INDEX_BITS;
  localparam int VEC_LINES   = 30;            // Directed cycles in the file.
  localparam int VEC_FIELDS  = 7;             // Words per vector line.
  localparam int RAND_CYCLES = 300;
  localparam int WATCHDOG    = (VEC_LINES + RAND_CYCLES + 20) * 8;

  logic        clk, rst, enable, was_branch, actual_taken;
  logic [15:0] actual_target, pc, predicted_target, id_pc;
  logic        predicted_taken, mispredicted;
  logic [15:0] vec_mem [VEC_LINES*VEC_FIELDS];
  int          n_checks, n_errors;

  // Model copy of the tables and the IF/ID stage.
  ctr_t  m_ctr [ENTRIES];
  addr_t m_tgt [ENTRIES];
  addr_t m_pc, m_id_pc, m_id_tgt;
  logic  m_id_pt;
  ctr_t  m_id_ctr;

  fetch_top #(.INDEX_BITS(INDEX_BITS)) u_fetch_top (
    .clk (clk), .rst (rst), .enable (enable),
    .was_branch (was_branch), .actual_taken (actual_taken), .actual_target (actual_target),
    .pc (pc), .predicted_taken (predicted_taken), .predicted_target (predicted_target),
    .mispredicted (mispredicted), .id_pc (id_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                    // Period of 8.
  end

  initial begin
    #(WATCHDOG);
    $display("Timeout: the run did not finish within %0d time units", WATCHDOG);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int group_last(input int g);   // Last vector line of each group.
    case (g)
      0: return 3;
      1: return 6;
      2: return 12;
      3: return 17;
      4: return 23;
      default: return 29;
    endcase
  endfunction

  function automatic string group_name(input int g);
    case (g)
      0: return "reset and sequential fetch";
      1: return "misprediction and redirect";
      2: return "counter training";
      3: return "target buffer";
      4: return "stall";
      default: return "counter saturation";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      n_errors++;
    end
  endtask

  task automatic drive_cycle(input logic en, input logic wb, input logic at, input addr_t tgt);
    @(negedge clk);
    enable        = en;
    was_branch    = wb;
    actual_taken  = at;
    actual_target = tgt;
    #3;                                       // Sample 1 unit before the rising edge.
  endtask

  // Expected outputs for this cycle, then the clock edge on the model state.
  task automatic model_step(input logic en, input logic wb, input logic at, input addr_t tgt,
                            input bit check);
    logic [INDEX_BITS-1:0] f_idx;
    logic [INDEX_BITS-1:0] d_idx;
    ctr_t  rd_ctr;
    addr_t rd_tgt;
    addr_t next_pc;
    logic  exp_mis;
    f_idx   = m_pc[INDEX_BITS:1];
    d_idx   = m_id_pc[INDEX_BITS:1];
    rd_ctr  = m_ctr[f_idx];                   // Read sees the old contents.
    rd_tgt  = m_tgt[f_idx];
    exp_mis = wb && ((at != m_id_pt) || (at && m_id_pt && (tgt != m_id_tgt)));
    if (check) begin
      check_value("pc", pc, m_pc);
      check_value("predicted_taken", predicted_taken, rd_ctr[1]);
      check_value("predicted_target", predicted_target, rd_tgt);
      check_value("mispredicted", mispredicted, exp_mis);
      check_value("id_pc", id_pc, m_id_pc);
    end
    if (en) begin
      if (exp_mis) next_pc = at ? tgt : m_id_pc + 16'd2;
      else if (rd_ctr[1]) next_pc = rd_tgt;
      else next_pc = m_pc + 16'd2;
      if (exp_mis) m_ctr[d_idx] = ctr_next(m_id_ctr, at);   // Counter trains on a miss only.
      if (wb && at) m_tgt[d_idx] = tgt;
      m_id_pc  = m_pc;
      m_id_pt  = rd_ctr[1];
      m_id_tgt = rd_tgt;
      m_id_ctr = rd_ctr;
      m_pc     = next_pc;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial begin
    int base;
    int grp;
    int grp_errs;
    logic [31:0] seed;
    addr_t r_tgt;
    rst = 1'b1;
    enable = 1'b1;
    was_branch = 1'b0;
    actual_taken = 1'b0;
    actual_target = '0;
    seed = 32'h9e240c7e;
    grp = 0;
    grp_errs = 0;
    for (int i = 0; i < ENTRIES; i++) begin
      m_ctr[i] = CTR_SNT;                     // Same start state as the tables.
      m_tgt[i] = '0;
    end
    m_pc = '0;
    m_id_pc = '0;
    m_id_tgt = '0;
    m_id_pt = 1'b0;
    m_id_ctr = CTR_SNT;
    $readmemh("testbench/fetch_vectors.mem", vec_mem);
    assert (!$isunknown(vec_mem[VEC_LINES*VEC_FIELDS-1])) else begin
      $display("The vector file is missing or holds fewer lines than expected");
      n_errors++;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    enable = 1'b0;                            // Idle cycle, state held.

    // Directed vectors.
    for (int i = 0; i < VEC_LINES; i++) begin
      base = i * VEC_FIELDS;
      drive_cycle(vec_mem[base][0], vec_mem[base+1][0], vec_mem[base+2][0], vec_mem[base+3]);
      check_value("pc", pc, vec_mem[base+4]);
      check_value("predicted_taken", predicted_taken, vec_mem[base+5]);
      check_value("mispredicted", mispredicted, vec_mem[base+6]);
      model_step(vec_mem[base][0], vec_mem[base+1][0], vec_mem[base+2][0], vec_mem[base+3],
                 1'b0);
      if (i == group_last(grp)) begin
        $display("%-28s %s (%0d errors)", group_name(grp),
                 (n_errors == grp_errs) ? "ok" : "FAILED", n_errors - grp_errs);
        grp_errs = n_errors;
        grp++;
      end
    end

    // Random cycles, loop-like targets in 0x40..0x5e.
    for (int i = 0; i < RAND_CYCLES; i++) begin
      seed = lcg_next(seed);
      r_tgt = 16'h0040 + {m_id_pc[INDEX_BITS:1], 1'b0} +
              ((seed[26:24] == 3'd0) ? 16'h0010 : 16'h0000);
      drive_cycle(seed[31:29] != 3'd0, seed[18:16] < 3'd3, seed[21:20] != 2'd0, r_tgt);
      model_step(enable, was_branch, actual_taken, actual_target, 1'b1);
    end
    $display("%-28s %s (%0d errors)", "random agreement",
             (n_errors == grp_errs) ? "ok" : "FAILED", n_errors - grp_errs);

    $display("Checks run: %0d, failed: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog/fetch_top.sv
////////////////////////////////////////////////////////////
// Instruction fetch front end.
// PC generator, branch predictor and branch resolver.
////////////////////////////////////////////////////////////
module fetch_top import bpu_pkg::*; #(
  parameter int INDEX_BITS = 3                // 8 predictor entries.
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,           // Pipeline advance.
  input  logic              was_branch,       // Decoder report on id_pc.
  input  logic              actual_taken,
  input  logic [ADDR_W-1:0] actual_target,
  output logic [ADDR_W-1:0] pc,               // Current fetch address.
  output logic              predicted_taken,
  output logic [ADDR_W-1:0] predicted_target,
  output logic              mispredicted,     // Also the fetch redirect.
  output logic [ADDR_W-1:0] id_pc
);

  ctr_t  pred_ctr;                            // Counter read at fetch.
  addr_t redirect_pc;

  bpu_update_if #(.INDEX_BITS(INDEX_BITS)) upd_if ();

  pc_gen u_pc_gen (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .redirect    (mispredicted),
    .redirect_pc (redirect_pc),
    .pred_taken  (predicted_taken),
    .pred_target (predicted_target),
    .fetch_pc    (pc)
  );

  branch_predictor #(.INDEX_BITS(INDEX_BITS)) u_branch_predictor (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .fetch_pc    (pc),
    .pred_taken  (predicted_taken),
    .pred_target (predicted_target),
    .pred_ctr    (pred_ctr),
    .upd         (upd_if.predictor)
  );

  branch_resolve #(.INDEX_BITS(INDEX_BITS)) u_branch_resolve (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .fetch_pc      (pc),
    .pred_taken    (predicted_taken),
    .pred_target   (predicted_target),
    .pred_ctr      (pred_ctr),
    .was_branch    (was_branch),
    .actual_taken  (actual_taken),
    .actual_target (actual_target),
    .redirect      (mispredicted),
    .redirect_pc   (redirect_pc),
    .id_pc         (id_pc),
    .upd           (upd_if.resolver)
  );

endmodule

// File: verilog/pc_gen.sv
////////////////////////////////////////////////////////////
// Fetch PC register and next-PC select.
////////////////////////////////////////////////////////////
module pc_gen import bpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  enable,                       // Low holds the PC.
  input  logic  redirect,                     // Correction from decode.
  input  addr_t redirect_pc,
  input  logic  pred_taken,                   // Predictor guess for fetch_pc.
  input  addr_t pred_target,
  output addr_t fetch_pc                      // Address fetched this cycle.
);

  addr_t next_pc;
  addr_t seq_pc;                              // Plain fall through.

  assign seq_pc = fetch_pc + 16'd2;           // One halfword instruction.

  ////////////////////////////////////////////////////////////
  // Next PC
  ////////////////////////////////////////////////////////////
  // Redirect wins over the guess, the guess over sequential flow.
  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;
    end else if (pred_taken) begin
      next_pc = pred_target;
    end else begin
      next_pc = seq_pc;
    end
  end

  ////////////////////////////////////////////////////////////
  // PC register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc <= '0;                         // Boot address.
    end else if (enable) begin
      fetch_pc <= next_pc;
    end
  end

endmodule

// File: verilog/branch_resolve.sv
////////////////////////////////////////////////////////////
// IF/ID stage for PC and prediction, misprediction check,
// fetch redirect and training update.
////////////////////////////////////////////////////////////
module branch_resolve import bpu_pkg::*; #(
  parameter int INDEX_BITS = 3
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  enable,                       // Low holds the stage.
  input  addr_t fetch_pc,
  input  logic  pred_taken,
  input  addr_t pred_target,
  input  ctr_t  pred_ctr,
  input  logic  was_branch,                   // Decoder report for the ID instruction.
  input  logic  actual_taken,
  input  addr_t actual_target,
  output logic  redirect,                     // Steer fetch this cycle.
  output addr_t redirect_pc,                  // Corrected fetch address.
  output addr_t id_pc,                        // PC of the instruction in ID.
  bpu_update_if.resolver upd
);

  logic  id_pred_taken;                       // Guess made at fetch.
  addr_t id_pred_target;
  ctr_t  id_pred_ctr;
  logic  mispredicted;

  ////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      id_pc          <= '0;
      id_pred_taken  <= 1'b0;                 // Nothing predicted yet.
      id_pred_target <= '0;
      id_pred_ctr    <= CTR_SNT;
    end else if (enable) begin
      id_pc          <= fetch_pc;
      id_pred_taken  <= pred_taken;
      id_pred_target <= pred_target;
      id_pred_ctr    <= pred_ctr;
    end
  end

  // Wrong direction, or right direction to the wrong place.
  assign mispredicted = was_branch &
                        ((actual_taken != id_pred_taken) |
                         (actual_taken & id_pred_taken & (actual_target != id_pred_target)));

  assign redirect    = mispredicted;
  assign redirect_pc = actual_taken ? actual_target : id_pc + 16'd2; // Fall through.

  // Training update for the predictor.
  assign upd.index         = id_pc[INDEX_BITS:1];
  assign upd.was_branch    = was_branch;
  assign upd.actual_taken  = actual_taken;
  assign upd.actual_target = actual_target;
  assign upd.mispredicted  = mispredicted;
  assign upd.fetched_ctr   = id_pred_ctr;

endmodule

// File: verilog/branch_predictor.sv
////////////////////////////////////////////////////////////
// Dynamic branch predictor.
// BHT of 2-bit counters and BTB of targets, trained from
// the resolved-branch update.
////////////////////////////////////////////////////////////
module branch_predictor import bpu_pkg::*; #(
  parameter int INDEX_BITS = 3                // PC bits INDEX_BITS..1 pick the slot.
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  enable,                       // Low freezes all training.
  input  addr_t fetch_pc,                     // PC being fetched this cycle.
  output logic  pred_taken,                   // Lookup says taken.
  output addr_t pred_target,                  // Lookup target.
  output ctr_t  pred_ctr,                     // Raw counter, kept for training.
  bpu_update_if.predictor upd                 // Update from the decode side.
);

  logic [INDEX_BITS-1:0] rd_index;            // Slot of the fetched PC.
  logic                  bht_we;              // Counter write strobe.
  ctr_t                  bht_wdata;           // Counter moved one step.
  logic                  btb_we;              // Target write strobe.

  // Halfword aligned, so bit 0 never takes part.
  assign rd_index = fetch_pc[INDEX_BITS:1];

  ////////////////////////////////////////////////////////////
  // Training
  ////////////////////////////////////////////////////////////
  // Counters move only when the guess was wrong.
  assign bht_we    = enable & upd.mispredicted;
  assign bht_wdata = ctr_next(upd.fetched_ctr, upd.actual_taken);

  // Any taken branch refreshes its target.
  assign btb_we = enable & upd.was_branch & upd.actual_taken;

  ////////////////////////////////////////////////////////////
  // Tables
  ////////////////////////////////////////////////////////////
  predictor_table #(
    .INDEX_BITS (INDEX_BITS),
    .entry_t    (ctr_t),
    .RESET_VAL  (CTR_SNT)                     // Start out strongly not taken.
  ) u_bht (
    .clk      (clk),
    .rst      (rst),
    .rd_index (rd_index),
    .rd_data  (pred_ctr),
    .wr_en    (bht_we),
    .wr_index (upd.index),
    .wr_data  (bht_wdata)
  );

  predictor_table #(
    .INDEX_BITS (INDEX_BITS),
    .entry_t    (addr_t),
    .RESET_VAL  (addr_t'(0))
  ) u_btb (
    .clk      (clk),
    .rst      (rst),
    .rd_index (rd_index),
    .rd_data  (pred_target),
    .wr_en    (btb_we),
    .wr_index (upd.index),
    .wr_data  (upd.actual_target)
  );

  assign pred_taken = pred_ctr[1];            // Upper counter bit is the guess.

endmodule

// File: verilog/predictor_table.sv
////////////////////////////////////////////////////////////
// Small untagged table, one async read port and one
// synchronous write port. Entry type set by parameter.
////////////////////////////////////////////////////////////
module predictor_table #(
  parameter int  INDEX_BITS = 3,              // log2 of the entry count.
  parameter type entry_t    = logic [15:0],   // Payload held per entry.
  parameter entry_t RESET_VAL = entry_t'(0)   // Value every entry takes on rst.
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [INDEX_BITS-1:0] rd_index,     // Lookup slot.
  output entry_t                rd_data,      // Lookup result, same cycle.
  input  logic                  wr_en,        // Write strobe.
  input  logic [INDEX_BITS-1:0] wr_index,     // Write slot.
  input  entry_t                wr_data       // Value to store.
);

  localparam int DEPTH = 2 ** INDEX_BITS;

  entry_t mem [DEPTH];                        // Table storage.

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= RESET_VAL;                  // Whole table back to its start value.
      end
    end else if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////
  // A write in this cycle only shows from the next one on.
  assign rd_data = mem[rd_index];

endmodule

// File: verilog/bpu_update_if.sv
////////////////////////////////////////////////////////////
// Resolved-branch update bundle, resolver to predictor.
////////////////////////////////////////////////////////////
interface bpu_update_if import bpu_pkg::*; #(
  parameter int INDEX_BITS = 3
) ();

  logic [INDEX_BITS-1:0] index;              // Table slot of the resolved instruction.
  logic                  was_branch;         // Decoder saw a branch.
  logic                  actual_taken;       // Resolved direction.
  addr_t                 actual_target;      // Resolved target.
  logic                  mispredicted;       // Prediction was wrong.
  ctr_t                  fetched_ctr;        // Counter as read at fetch time.

  // Decode side drives the update.
  modport resolver (output index, was_branch, actual_taken, actual_target,
                    output mispredicted, fetched_ctr);

  // Fetch side trains its tables from it.
  modport predictor (input index, was_branch, actual_taken, actual_target,
                     input mispredicted, fetched_ctr);

endinterface

// File: verilog/bpu_pkg.sv
////////////////////////////////////////////////////////////
// Shared fetch front end definitions.
// Address type, 2-bit history counter and its update step.
////////////////////////////////////////////////////////////
package bpu_pkg;

  localparam int ADDR_W = 16;                // Byte address width.

  typedef logic [ADDR_W-1:0] addr_t;         // PCs and branch targets.

  // 2-bit saturating counter, upper bit is the taken prediction.
  typedef enum logic [1:0] {
    CTR_SNT = 2'd0,                          // Strong not taken.
    CTR_WNT = 2'd1,                          // Weak not taken.
    CTR_WT  = 2'd2,                          // Weak taken.
    CTR_ST  = 2'd3                           // Strong taken.
  } ctr_t;

  // One step toward the resolved direction, held at both ends.
  function automatic ctr_t ctr_next(ctr_t cur, logic taken);
    ctr_t nxt;
    case (cur)
      CTR_SNT: nxt = taken ? CTR_WNT : CTR_SNT;
      CTR_WNT: nxt = taken ? CTR_WT  : CTR_SNT;
      CTR_WT:  nxt = taken ? CTR_ST  : CTR_WNT;
      CTR_ST:  nxt = taken ? CTR_ST  : CTR_WT;
      default: nxt = CTR_SNT;                // X state falls back to not taken.
    endcase
    return nxt;
  endfunction

endpackage
